// ==== logic/dcache_pkg.sv ====
// dcache shared definitions
// sizes of the two-way set-associative array, write source codes
// and the line type seen either whole or as four words
package dcache_pkg;

    localparam int INDEX_W  = 8;
    localparam int SETS     = 1 << INDEX_W;     // 256 sets
    localparam int TAG_W    = 20;
    localparam int WORD_W   = 32;
    localparam int N_WORDS  = 4;                // words per line
    localparam int OFFSET_W = 2;
    localparam int LINE_W   = N_WORDS * WORD_W; // 128 bits

    // granted write source
    localparam int SRC_W = 2;

    localparam logic [SRC_W-1:0] SRC_NONE  = 2'd0;
    localparam logic [SRC_W-1:0] SRC_L2    = 2'd1;
    localparam logic [SRC_W-1:0] SRC_MEM   = 2'd2;
    localparam logic [SRC_W-1:0] SRC_STORE = 2'd3;

    // refills use the whole line, stores and word RAMs use the word view
    typedef union packed {
        logic [LINE_W-1:0]              line;
        logic [N_WORDS-1:0][WORD_W-1:0] words; // words[0] is bits 31:0
    } dcache_line_u;

endpackage

// ==== logic/ram256x32.sv ====
// single-port 256 x 32 synchronous RAM
// one-cycle write, registered read with read-before-write
module ram256x32 (
    input  logic                           clk,
    input  logic [dcache_pkg::INDEX_W-1:0] address,
    input  logic                           wren,
    input  logic                           rden,
    input  logic [dcache_pkg::WORD_W-1:0]  data,
    output logic [dcache_pkg::WORD_W-1:0]  q
);

    logic [dcache_pkg::WORD_W-1:0] mem [dcache_pkg::SETS];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
        end
        if (rden) begin
            q <= mem[address]; // old word on a same-cycle write
        end
    end

endmodule

// ==== logic/write_arbiter.sv ====
// dcache write arbiter
// fixed priority L2 refill, memory refill, store; the loser is dropped
// stores go only to the way that hit at the last lookup
module write_arbiter (
    input  logic                            l2_fill_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  l2_fill_index,
    input  logic [dcache_pkg::TAG_W-1:0]    l2_fill_tag,
    input  logic                            l2_fill_way,
    input  logic [dcache_pkg::LINE_W-1:0]   l2_fill_line,
    input  logic                            mem_fill_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  mem_fill_index,
    input  logic [dcache_pkg::TAG_W-1:0]    mem_fill_tag,
    input  logic                            mem_fill_way,
    input  logic [dcache_pkg::LINE_W-1:0]   mem_fill_line,
    input  logic                            store_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  store_index,
    input  logic [dcache_pkg::OFFSET_W-1:0] store_offset,
    input  logic [dcache_pkg::WORD_W-1:0]   store_word,
    input  logic                            hit0,
    input  logic                            hit1,
    output logic                            wr_active,
    output logic [dcache_pkg::SRC_W-1:0]    wr_src,
    output logic [dcache_pkg::INDEX_W-1:0]  wr_index,
    output logic [dcache_pkg::TAG_W-1:0]    wr_tag,
    output dcache_pkg::dcache_line_u        wr_line,
    output logic [dcache_pkg::OFFSET_W-1:0] wr_offset,
    output logic                            wr_way0,
    output logic                            wr_way1
);

    logic store_ok;

    assign store_ok  = store_en && (hit0 || hit1); // write-no-allocate
    assign wr_offset = store_offset;               // only decoded for stores

    always_comb begin
        wr_src   = dcache_pkg::SRC_NONE;
        wr_index = store_index;
        wr_tag   = '0;
        wr_line  = '0;
        wr_way0  = 1'b0;
        wr_way1  = 1'b0;
        if (l2_fill_en) begin
            wr_src       = dcache_pkg::SRC_L2;
            wr_index     = l2_fill_index;
            wr_tag       = l2_fill_tag;
            wr_line.line = l2_fill_line;
            wr_way0      = !l2_fill_way;
            wr_way1      = l2_fill_way;
        end else if (mem_fill_en) begin
            wr_src       = dcache_pkg::SRC_MEM;
            wr_index     = mem_fill_index;
            wr_tag       = mem_fill_tag;
            wr_line.line = mem_fill_line;
            wr_way0      = !mem_fill_way;
            wr_way1      = mem_fill_way;
        end else if (store_ok) begin
            wr_src                      = dcache_pkg::SRC_STORE;
            wr_line.words[store_offset] = store_word; // other words masked off
            wr_way0                     = hit0;
            wr_way1                     = hit1;
        end
    end

    assign wr_active = (wr_src != dcache_pkg::SRC_NONE);

endmodule

// ==== logic/data_ram.sv ====
// dcache data array
// two ways of four 256 x 32 word RAMs, one port shared by writes and lookups
// refills write all words of a way, stores only the offset word
module data_ram (
    input  logic                            clk,
    input  logic                            lookup_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  lookup_index,
    input  logic                            wr_active,
    input  logic [dcache_pkg::SRC_W-1:0]    wr_src,
    input  logic [dcache_pkg::INDEX_W-1:0]  wr_index,
    input  dcache_pkg::dcache_line_u        wr_line,
    input  logic [dcache_pkg::OFFSET_W-1:0] wr_offset,
    input  logic                            wr_way0,
    input  logic                            wr_way1,
    output logic [dcache_pkg::LINE_W-1:0]   data0_rd,
    output logic [dcache_pkg::LINE_W-1:0]   data1_rd
);

    logic [dcache_pkg::INDEX_W-1:0]  ram_index;
    logic                            ram_rden;
    logic [dcache_pkg::N_WORDS-1:0]  word_we;
    logic [1:0][dcache_pkg::N_WORDS-1:0] way_we;

    dcache_pkg::dcache_line_u rd_line [2];

    // write owns the port, a lookup in the same cycle is dropped
    assign ram_index = wr_active ? wr_index : lookup_index;
    assign ram_rden  = lookup_en && !wr_active; // q holds when not read

    // word mask for the write
    always_comb begin
        word_we = '0;
        if (wr_active) begin
            if (wr_src == dcache_pkg::SRC_STORE) begin
                word_we[wr_offset] = 1'b1;
            end else begin
                word_we = '1; // whole line refill
            end
        end
    end

    assign way_we[0] = word_we & {dcache_pkg::N_WORDS{wr_way0}};
    assign way_we[1] = word_we & {dcache_pkg::N_WORDS{wr_way1}};

    for (genvar way = 0; way < 2; way++) begin : g_way
        for (genvar w = 0; w < dcache_pkg::N_WORDS; w++) begin : g_word
            ram256x32 u_ram (
                .clk     (clk),
                .address (ram_index),
                .wren    (way_we[way][w]),
                .rden    (ram_rden),
                .data    (wr_line.words[w]),
                .q       (rd_line[way].words[w])
            );
        end
    end

    assign data0_rd = rd_line[0].line;
    assign data1_rd = rd_line[1].line;

endmodule

// ==== logic/tag_ram.sv ====
// dcache tag array
// tag and valid per way and set, lookup registers both ways and compares
// against the registered lookup tag to give hit0 and hit1
module tag_ram (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           lookup_en,
    input  logic [dcache_pkg::INDEX_W-1:0] lookup_index,
    input  logic [dcache_pkg::TAG_W-1:0]   lookup_tag,
    input  logic                           wr_active,
    input  logic [dcache_pkg::SRC_W-1:0]   wr_src,
    input  logic [dcache_pkg::INDEX_W-1:0] wr_index,
    input  logic [dcache_pkg::TAG_W-1:0]   wr_tag,
    input  logic                           wr_way0,
    input  logic                           wr_way1,
    output logic                           hit0,
    output logic                           hit1
);

    logic [dcache_pkg::TAG_W-1:0] tag_mem [2][dcache_pkg::SETS];
    logic [1:0][dcache_pkg::SETS-1:0] valid;

    logic [dcache_pkg::TAG_W-1:0] rd_tag [2];
    logic [1:0]                   rd_valid;
    logic [dcache_pkg::TAG_W-1:0] cmp_tag;  // tag of the last accepted lookup

    logic       fill;
    logic [1:0] way_we;
    logic       lookup_ok;

    // stores leave tags and valids alone
    assign fill      = wr_active && (wr_src != dcache_pkg::SRC_STORE);
    assign way_we    = {wr_way1, wr_way0} & {2{fill}};
    assign lookup_ok = lookup_en && !wr_active;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way_we[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            if (lookup_ok) begin
                rd_tag[w] <= tag_mem[w][lookup_index];
            end
        end
        if (lookup_ok) begin
            cmp_tag <= lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= '0;
            rd_valid <= '0; // keeps hits low until a lookup
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (way_we[w]) begin
                    valid[w][wr_index] <= 1'b1;
                end
                if (lookup_ok) begin
                    rd_valid[w] <= valid[w][lookup_index];
                end
            end
        end
    end

    assign hit0 = rd_valid[0] && (rd_tag[0] == cmp_tag);
    assign hit1 = rd_valid[1] && (rd_tag[1] == cmp_tag);

endmodule

// ==== logic/dcache_top.sv ====
// two-way set-associative data cache array
// write arbiter in front of the tag and data arrays
module dcache_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            lookup_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  lookup_index,
    input  logic [dcache_pkg::TAG_W-1:0]    lookup_tag,
    input  logic                            l2_fill_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  l2_fill_index,
    input  logic [dcache_pkg::TAG_W-1:0]    l2_fill_tag,
    input  logic                            l2_fill_way,
    input  logic [dcache_pkg::LINE_W-1:0]   l2_fill_line,
    input  logic                            mem_fill_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  mem_fill_index,
    input  logic [dcache_pkg::TAG_W-1:0]    mem_fill_tag,
    input  logic                            mem_fill_way,
    input  logic [dcache_pkg::LINE_W-1:0]   mem_fill_line,
    input  logic                            store_en,
    input  logic [dcache_pkg::INDEX_W-1:0]  store_index,
    input  logic [dcache_pkg::OFFSET_W-1:0] store_offset,
    input  logic [dcache_pkg::WORD_W-1:0]   store_word,
    output logic                            hit0,
    output logic                            hit1,
    output logic [dcache_pkg::LINE_W-1:0]   data0_rd,
    output logic [dcache_pkg::LINE_W-1:0]   data1_rd
);

    logic                            wr_active;
    logic [dcache_pkg::SRC_W-1:0]    wr_src;
    logic [dcache_pkg::INDEX_W-1:0]  wr_index;
    logic [dcache_pkg::TAG_W-1:0]    wr_tag;
    dcache_pkg::dcache_line_u        wr_line;
    logic [dcache_pkg::OFFSET_W-1:0] wr_offset;
    logic                            wr_way0;
    logic                            wr_way1;

    write_arbiter u_arb (
        .l2_fill_en     (l2_fill_en),
        .l2_fill_index  (l2_fill_index),
        .l2_fill_tag    (l2_fill_tag),
        .l2_fill_way    (l2_fill_way),
        .l2_fill_line   (l2_fill_line),
        .mem_fill_en    (mem_fill_en),
        .mem_fill_index (mem_fill_index),
        .mem_fill_tag   (mem_fill_tag),
        .mem_fill_way   (mem_fill_way),
        .mem_fill_line  (mem_fill_line),
        .store_en       (store_en),
        .store_index    (store_index),
        .store_offset   (store_offset),
        .store_word     (store_word),
        .hit0           (hit0),         // store way comes from the last lookup
        .hit1           (hit1),
        .wr_active      (wr_active),
        .wr_src         (wr_src),
        .wr_index       (wr_index),
        .wr_tag         (wr_tag),
        .wr_line        (wr_line),
        .wr_offset      (wr_offset),
        .wr_way0        (wr_way0),
        .wr_way1        (wr_way1)
    );

    tag_ram u_tag (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .wr_active    (wr_active),
        .wr_src       (wr_src),
        .wr_index     (wr_index),
        .wr_tag       (wr_tag),
        .wr_way0      (wr_way0),
        .wr_way1      (wr_way1),
        .hit0         (hit0),
        .hit1         (hit1)
    );

    data_ram u_data (
        .clk          (clk),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .wr_active    (wr_active),
        .wr_src       (wr_src),
        .wr_index     (wr_index),
        .wr_line      (wr_line),
        .wr_offset    (wr_offset),
        .wr_way0      (wr_way0),
        .wr_way1      (wr_way1),
        .data0_rd     (data0_rd),
        .data1_rd     (data1_rd)
    );

endmodule

// ==== test/dcache_assertions.sv ====
// dcache port checker
// watches the cache top ports and checks refill, store and lookup results
// against the write rules, counting each failed check
module dcache_assertions (
    input logic                            clk,
    input logic                            rst,
    input logic                            lookup_en,
    input logic [dcache_pkg::INDEX_W-1:0]  lookup_index,
    input logic [dcache_pkg::TAG_W-1:0]    lookup_tag,
    input logic                            l2_fill_en,
    input logic [dcache_pkg::INDEX_W-1:0]  l2_fill_index,
    input logic [dcache_pkg::TAG_W-1:0]    l2_fill_tag,
    input logic                            l2_fill_way,
    input logic [dcache_pkg::LINE_W-1:0]   l2_fill_line,
    input logic                            mem_fill_en,
    input logic [dcache_pkg::INDEX_W-1:0]  mem_fill_index,
    input logic [dcache_pkg::TAG_W-1:0]    mem_fill_tag,
    input logic                            mem_fill_way,
    input logic [dcache_pkg::LINE_W-1:0]   mem_fill_line,
    input logic                            store_en,
    input logic [dcache_pkg::INDEX_W-1:0]  store_index,
    input logic [dcache_pkg::OFFSET_W-1:0] store_offset,
    input logic [dcache_pkg::WORD_W-1:0]   store_word,
    input logic                            hit0,
    input logic                            hit1,
    input logic [dcache_pkg::LINE_W-1:0]   data0_rd,
    input logic [dcache_pkg::LINE_W-1:0]   data1_rd
);

    logic                           lookup_ok;
    logic                           seen_fill;
    logic [dcache_pkg::INDEX_W-1:0] last_index;
    logic [dcache_pkg::TAG_W-1:0]   last_tag;

    int unsigned early_hit_errors  = 0;
    int unsigned l2_fill_errors    = 0;
    int unsigned mem_fill_errors   = 0;
    int unsigned clash_errors      = 0;
    int unsigned store_hit_errors  = 0;
    int unsigned store_miss_errors = 0;
    int unsigned dual_hit_errors   = 0;

    // any granted write takes the port from the lookup
    assign lookup_ok = lookup_en && !(l2_fill_en || mem_fill_en || (store_en && (hit0 || hit1)));

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_fill <= 1'b0;
        end else if (l2_fill_en || mem_fill_en) begin
            seen_fill <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_ok) begin
            last_index <= lookup_index; // set and tag behind the current hits
            last_tag   <= lookup_tag;
        end
    end

    function automatic logic [dcache_pkg::LINE_W-1:0] put_word(
        input logic [dcache_pkg::LINE_W-1:0]   line,
        input logic [dcache_pkg::OFFSET_W-1:0] offset,
        input logic [dcache_pkg::WORD_W-1:0]   word
    );
        logic [dcache_pkg::LINE_W-1:0] result;
        result = line;
        result[offset*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] = word;
        return result;
    endfunction

    a_early_hit: assert property (@(posedge clk) disable iff (rst)
        !seen_fill |-> !hit0 && !hit1)
    else begin
        early_hit_errors++;
        $error("ERROR %0t: hit before any refill", $time);
    end

    a_l2_fill: assert property (@(posedge clk) disable iff (rst)
        $past(l2_fill_en, 2) && $past(lookup_ok)
        && $past(lookup_index) == $past(l2_fill_index, 2)
        && $past(lookup_tag) == $past(l2_fill_tag, 2)
        |-> ($past(l2_fill_way, 2) ? (hit1 && data1_rd === $past(l2_fill_line, 2))
                                   : (hit0 && data0_rd === $past(l2_fill_line, 2))))
    else begin
        l2_fill_errors++;
        $error("ERROR %0t: lookup after L2 refill gave wrong hit or line", $time);
    end

    a_mem_fill: assert property (@(posedge clk) disable iff (rst)
        $past(mem_fill_en && !l2_fill_en, 2) && $past(lookup_ok)
        && $past(lookup_index) == $past(mem_fill_index, 2)
        && $past(lookup_tag) == $past(mem_fill_tag, 2)
        |-> ($past(mem_fill_way, 2) ? (hit1 && data1_rd === $past(mem_fill_line, 2))
                                    : (hit0 && data0_rd === $past(mem_fill_line, 2))))
    else begin
        mem_fill_errors++;
        $error("ERROR %0t: lookup after memory refill gave wrong hit or line", $time);
    end

    // holds for sets that had no earlier copy of the memory tag
    a_fill_clash: assert property (@(posedge clk) disable iff (rst)
        $past(l2_fill_en && mem_fill_en && mem_fill_tag != l2_fill_tag, 2)
        && $past(lookup_ok) && $past(lookup_index) == $past(mem_fill_index, 2)
        && $past(lookup_tag) == $past(mem_fill_tag, 2)
        |-> !hit0 && !hit1)
    else begin
        clash_errors++;
        $error("ERROR %0t: memory refill that lost to L2 still hits", $time);
    end

    a_store_hit: assert property (@(posedge clk) disable iff (rst)
        $past(store_en && (hit0 || hit1) && !l2_fill_en && !mem_fill_en, 2)
        && $past(store_index, 2) == $past(last_index, 2) && $past(lookup_ok)
        && $past(lookup_index) == $past(last_index, 2)
        && $past(lookup_tag) == $past(last_tag, 2)
        |-> ($past(hit1, 2)
            ? (hit1 && data1_rd === put_word($past(data1_rd, 2), $past(store_offset, 2),
                                             $past(store_word, 2)))
            : (hit0 && data0_rd === put_word($past(data0_rd, 2), $past(store_offset, 2),
                                             $past(store_word, 2)))))
    else begin
        store_hit_errors++;
        $error("ERROR %0t: line after store hit differs from expected", $time);
    end

    a_store_miss: assert property (@(posedge clk) disable iff (rst)
        $past(store_en && !hit0 && !hit1 && !l2_fill_en && !mem_fill_en, 2)
        && $past(store_index, 2) == $past(last_index, 2) && $past(lookup_ok)
        && $past(lookup_index) == $past(last_index, 2)
        && $past(lookup_tag) == $past(last_tag, 2)
        |-> data0_rd === $past(data0_rd, 2) && data1_rd === $past(data1_rd, 2))
    else begin
        store_miss_errors++;
        $error("ERROR %0t: store on a miss changed the set", $time);
    end

    a_dual_hit: assert property (@(posedge clk) disable iff (rst)
        !(hit0 && hit1))
    else begin
        dual_hit_errors++;
        $error("ERROR %0t: both ways hit", $time);
    end

endmodule

bind dcache_top dcache_assertions u_assert (.*);

// ==== test/dcache_tb.sv ====
// dcache testbench
// random refills, lookups and stores into the cache top, the bound
// checker judges the results and this bench reports its failure counts
module dcache_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int FILL_LOOPS     = 32; // 4 cycles each
    localparam int CLASH_LOOPS    = 6;  // 3 cycles each
    localparam int MISS_LOOPS     = 5;  // 5 cycles each
    localparam int TAIL_CYCLES    = 9;
    localparam int RUN_CYCLES     = RESET_CYCLES + 4 + FILL_LOOPS * 4 + CLASH_LOOPS * 3
                                    + MISS_LOOPS * 5 + TAIL_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    logic                            clk;
    logic                            rst;
    logic                            lookup_en;
    logic [dcache_pkg::INDEX_W-1:0]  lookup_index;
    logic [dcache_pkg::TAG_W-1:0]    lookup_tag;
    logic                            l2_fill_en;
    logic [dcache_pkg::INDEX_W-1:0]  l2_fill_index;
    logic [dcache_pkg::TAG_W-1:0]    l2_fill_tag;
    logic                            l2_fill_way;
    logic [dcache_pkg::LINE_W-1:0]   l2_fill_line;
    logic                            mem_fill_en;
    logic [dcache_pkg::INDEX_W-1:0]  mem_fill_index;
    logic [dcache_pkg::TAG_W-1:0]    mem_fill_tag;
    logic                            mem_fill_way;
    logic [dcache_pkg::LINE_W-1:0]   mem_fill_line;
    logic                            store_en;
    logic [dcache_pkg::INDEX_W-1:0]  store_index;
    logic [dcache_pkg::OFFSET_W-1:0] store_offset;
    logic [dcache_pkg::WORD_W-1:0]   store_word;
    logic                            hit0;
    logic                            hit1;
    logic [dcache_pkg::LINE_W-1:0]   data0_rd;
    logic [dcache_pkg::LINE_W-1:0]   data1_rd;

    int          cycle_count = 0;
    logic [31:0] lcg_state   = 32'd76348;

    dcache_top dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [dcache_pkg::LINE_W-1:0] fresh_line();
        return {rand32(), rand32(), rand32(), rand32()};
    endfunction

    // drive tasks only set inputs and step closes the cycle
    task automatic lookup_req(input logic [7:0] index, input logic [19:0] tag);
        lookup_en    <= 1'b1;
        lookup_index <= index;
        lookup_tag   <= tag;
    endtask

    task automatic l2_refill(input logic [7:0] index, input logic [19:0] tag, input logic way,
                             input logic [dcache_pkg::LINE_W-1:0] line);
        l2_fill_en    <= 1'b1;
        l2_fill_index <= index;
        l2_fill_tag   <= tag;
        l2_fill_way   <= way;
        l2_fill_line  <= line;
    endtask

    task automatic mem_refill(input logic [7:0] index, input logic [19:0] tag, input logic way,
                              input logic [dcache_pkg::LINE_W-1:0] line);
        mem_fill_en    <= 1'b1;
        mem_fill_index <= index;
        mem_fill_tag   <= tag;
        mem_fill_way   <= way;
        mem_fill_line  <= line;
    endtask

    task automatic store_req(input logic [7:0] index, input logic [1:0] offset,
                             input logic [31:0] word);
        store_en     <= 1'b1;
        store_index  <= index;
        store_offset <= offset;
        store_word   <= word;
    endtask

    task automatic step();
        @(posedge clk);
        lookup_en   <= 1'b0;
        l2_fill_en  <= 1'b0;
        mem_fill_en <= 1'b0;
        store_en    <= 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0]                 r;
        logic [7:0]                  index;
        logic [19:0]                 tag;
        logic [19:0]                 other_tag;
        logic                        way;
        int unsigned                 total;
        clk            = 1'b0;
        rst            = 1'b1;
        lookup_en      = 1'b0;
        lookup_index   = '0;
        lookup_tag     = '0;
        l2_fill_en     = 1'b0;
        l2_fill_index  = '0;
        l2_fill_tag    = '0;
        l2_fill_way    = 1'b0;
        l2_fill_line   = '0;
        mem_fill_en    = 1'b0;
        mem_fill_index = '0;
        mem_fill_tag   = '0;
        mem_fill_way   = 1'b0;
        mem_fill_line  = '0;
        store_en       = 1'b0;
        store_index    = '0;
        store_offset   = '0;
        store_word     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // nothing may hit in the empty cache
        repeat (4) begin
            r = rand32();
            lookup_req(r[7:0], r[27:8]);
            step();
        end

        // refill, hit lookup, store into the hit way, lookup again
        for (int i = 0; i < FILL_LOOPS; i++) begin
            r     = rand32();
            index = {1'b0, r[6:0]}; // sets 128 and up stay free for the clash loop
            way   = r[7];
            tag   = {r[26:8], way}; // tag lsb = way, so the ways never share a tag
            if (i % 2 == 0) begin
                l2_refill(index, tag, way, fresh_line());
            end else begin
                mem_refill(index, tag, way, fresh_line());
            end
            step();
            lookup_req(index, tag);
            step();
            r = rand32();
            store_req(index, r[1:0], rand32());
            step();
            lookup_req(index, tag);
            step();
        end

        // L2 and memory refill in the same cycle into fresh sets
        for (int i = 0; i < CLASH_LOOPS; i++) begin
            r         = rand32();
            index     = 8'h80 + 8'(i);
            tag       = {r[18:0], 1'b0};
            other_tag = {r[31:13], 1'b1};
            l2_refill(index, tag, r[0], fresh_line());
            mem_refill(index, other_tag, r[1], fresh_line());
            step();
            lookup_req(index, other_tag);
            step();
            lookup_req(index, tag);
            step();
        end

        // both ways filled, then a store that misses
        for (int i = 0; i < MISS_LOOPS; i++) begin
            r         = rand32();
            index     = {1'b0, r[6:0]};
            tag       = {r[26:8], 1'b0};
            other_tag = {r[31:13], 1'b1};
            l2_refill(index, tag, 1'b0, fresh_line());
            step();
            mem_refill(index, other_tag, 1'b1, fresh_line());
            step();
            lookup_req(index, tag ^ 20'h2); // matches neither way
            step();
            store_req(index, r[1:0], rand32());
            step();
            lookup_req(index, tag ^ 20'h2);
            step();
        end

        repeat (TAIL_CYCLES) step();

        total = dut.u_assert.early_hit_errors + dut.u_assert.l2_fill_errors
              + dut.u_assert.mem_fill_errors + dut.u_assert.clash_errors
              + dut.u_assert.store_hit_errors + dut.u_assert.store_miss_errors
              + dut.u_assert.dual_hit_errors;
        $write("assertion failures: early_hit=%0d l2_fill=%0d mem_fill=%0d clash=%0d ",
               dut.u_assert.early_hit_errors, dut.u_assert.l2_fill_errors,
               dut.u_assert.mem_fill_errors, dut.u_assert.clash_errors);
        $display("store_hit=%0d store_miss=%0d dual_hit=%0d total=%0d",
                 dut.u_assert.store_hit_errors, dut.u_assert.store_miss_errors,
                 dut.u_assert.dual_hit_errors, total);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
logic/dcache_pkg.sv
logic/ram256x32.sv
logic/write_arbiter.sv
logic/data_ram.sv
logic/tag_ram.sv
logic/dcache_top.sv
test/dcache_assertions.sv
test/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
